/* filelist.f */
+incdir+verilog
verilog/vga_pkg.sv
verilog/skid_buf.sv
verilog/video_mode_regs.sv
verilog/pattern_gen.sv
verilog/pix_vga.sv
verilog/vga_subsys_top.sv
sim/tb_vga_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the VGA subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  -f filelist.f --top-module tb_vga_subsys -o tb_vga_subsys

output="$(./obj_dir/tb_vga_subsys)"
echo "$output"

if grep -qF '** PASS **' <<< "$output"; then
  exit 0
else
  exit 1
fi

/* sim/tb_vga_subsys.sv */
`timescale 1ns/1ps
`include "vga_macros.svh"

module tb_vga_subsys;
  localparam int CLK_PERIOD    = 20;
  localparam int H_VIS         = 8;
  localparam int H_SS          = 10;
  localparam int H_SE          = 12;
  localparam int H_LE          = 13;
  localparam int H_LE2         = 17;                     // widened line for reprogramming
  localparam int V_VIS         = 4;
  localparam int V_SS          = 5;
  localparam int V_SE          = 6;
  localparam int V_FE          = 7;
  localparam int LINE_CYCLES   = H_LE + 1;
  localparam int FRAME_CYCLES  = LINE_CYCLES * (V_FE + 1);
  localparam int FRAME2_CYCLES = (H_LE2 + 1) * (V_FE + 1);
  localparam int WAIT_LIMIT    = 2 * FRAME2_CYCLES;
  localparam int TEST_FRAMES   = 14;                     // rough frame count of all tests
  localparam int WATCHDOG_NS   = (TEST_FRAMES * FRAME2_CYCLES + 200) * CLK_PERIOD;

  logic                           clk = 1'b0;
  logic                           rst_n;
  logic                           wr_en;
  logic [`VGA_REG_ADDR_WIDTH-1:0] wr_addr;
  logic [`VGA_REG_DATA_WIDTH-1:0] wr_data;
  logic                           vga_hsync;
  logic                           vga_vsync;
  vga_pkg::pixel_t                vga_rgb;
  logic                           vga_error;

  int cycle = 0;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  vga_subsys_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_rgb  (vga_rgb),
    .vga_error(vga_error)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("error at %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    if (errors == err_start) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_start);
    end
  endtask

  task automatic reg_write(input logic [`VGA_REG_ADDR_WIDTH-1:0] addr,
                           input logic [`VGA_REG_DATA_WIDTH-1:0] data);
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    @(posedge clk);
    wr_en   <= 1'b0;
  endtask

  task automatic program_mode(input int line_end, input bit enable);
    reg_write(vga_pkg::REG_H_VISIBLE, 16'(H_VIS));
    reg_write(vga_pkg::REG_H_SYNC_START, 16'(H_SS));
    reg_write(vga_pkg::REG_H_SYNC_END, 16'(H_SE));
    reg_write(vga_pkg::REG_H_LINE_END, 16'(line_end));
    reg_write(vga_pkg::REG_V_VISIBLE, 16'(V_VIS));
    reg_write(vga_pkg::REG_V_SYNC_START, 16'(V_SS));
    reg_write(vga_pkg::REG_V_SYNC_END, 16'(V_SE));
    reg_write(vga_pkg::REG_V_FRAME_END, 16'(V_FE));
    reg_write(vga_pkg::REG_CTRL, 16'(enable));
    reg_write(vga_pkg::REG_COMMIT, 16'h0000);
  endtask

  // expected color of the k-th visible pixel of a frame
  function automatic vga_pkg::pixel_t pattern_pixel(input int k, input int h_vis);
    vga_pkg::pixel_t p;
    int              px;
    int              py;
    px    = k % h_vis;
    py    = k / h_vis;
    p.red = px[`VGA_COLOR_WIDTH-1:0];
    p.grn = py[`VGA_COLOR_WIDTH-1:0];
    p.blu = '1;
    return p;
  endfunction

  function automatic logic sync_level(input bit use_v);
    return use_v ? vga_vsync : vga_hsync;
  endfunction

  task automatic wait_sync_edge(input bit use_v, input bit rising, output int at_cycle);
    logic prev;
    logic cur;
    int   n;
    at_cycle = -1;
    n        = 0;
    @(negedge clk);
    prev = sync_level(use_v);
    while (at_cycle < 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      cur = sync_level(use_v);
      if (rising ? (!prev && cur) : (prev && !cur)) begin
        at_cycle = cycle;
      end
      prev = cur;
      n++;
    end
    check_true(at_cycle >= 0, $sformatf("no %s edge on %s within %0d cycles",
               rising ? "rising" : "falling", use_v ? "vga_vsync" : "vga_hsync", WAIT_LIMIT));
  endtask

  // runs up to the next vsync rise, n_late counts colors seen after an underflow
  task automatic scan_frame(input bit expect_pattern, output int n_pix, output int n_err,
                            output int n_late);
    logic prev;
    logic cur;
    bit   done;
    int   n;
    n_pix  = 0;
    n_err  = 0;
    n_late = 0;
    done   = 1'b0;
    n      = 0;
    @(negedge clk);
    prev = vga_vsync;
    while (!done && n < WAIT_LIMIT) begin
      @(negedge clk);
      cur = vga_vsync;
      if (!prev && cur) begin
        done = 1'b1;
      end else begin
        if (vga_rgb != '0) begin
          if (expect_pattern) begin
            check_val("vga_rgb", int'(vga_rgb), int'(pattern_pixel(n_pix, H_VIS)));
          end
          if (n_err > 0) n_late++;
          n_pix++;
        end
        if (vga_error) n_err++;
      end
      prev = cur;
      n++;
    end
    check_true(done, "vsync did not rise again within the scan limit");
  endtask

  task automatic test_reset_state();
    int err_start;
    err_start = errors;
    repeat (20) begin
      @(negedge clk);
      check_val("vga_hsync", int'(vga_hsync), 1);
      check_val("vga_vsync", int'(vga_vsync), 1);
      check_val("vga_rgb", int'(vga_rgb), 0);
      check_val("vga_error", int'(vga_error), 0);
    end
    finish_test("reset_state", err_start);
  endtask

  task automatic test_hsync_timing();
    int err_start;
    int t_fall;
    int t_rise;
    int t_next;
    err_start = errors;
    program_mode(H_LE, 1'b1);
    wait_sync_edge(1'b0, 1'b0, t_fall);
    repeat (3) begin
      wait_sync_edge(1'b0, 1'b1, t_rise);
      wait_sync_edge(1'b0, 1'b0, t_next);
      check_val("vga_hsync low width", t_rise - t_fall, H_SE - H_SS);
      check_val("vga_hsync period", t_next - t_fall, H_LE + 1);
      t_fall = t_next;
    end
    finish_test("hsync_timing", err_start);
  endtask

  task automatic test_vsync_timing();
    int err_start;
    int t_fall;
    int t_rise;
    int t_next;
    err_start = errors;
    wait_sync_edge(1'b1, 1'b0, t_fall);
    wait_sync_edge(1'b1, 1'b1, t_rise);
    wait_sync_edge(1'b1, 1'b0, t_next);
    check_val("vga_vsync low width", t_rise - t_fall, (V_SE - V_SS) * LINE_CYCLES);
    check_val("vga_vsync period", t_next - t_fall, FRAME_CYCLES);
    finish_test("vsync_timing", err_start);
  endtask

  task automatic test_pixel_content();
    int err_start;
    int t_rise;
    int n_pix;
    int n_err;
    int n_late;
    err_start = errors;
    wait_sync_edge(1'b1, 1'b1, t_rise);
    scan_frame(1'b1, n_pix, n_err, n_late);
    check_val("vga_rgb pixels per frame", n_pix, H_VIS * V_VIS);
    check_val("vga_error pulses", n_err, 0);
    finish_test("pixel_content", err_start);
  endtask

  task automatic test_reprogram();
    int err_start;
    int t_commit;
    int t_fall;
    int t_next;
    int period;
    int n;
    int n_pix;
    int n_err;
    int n_late;
    err_start = errors;
    reg_write(vga_pkg::REG_H_LINE_END, 16'(H_LE2));
    reg_write(vga_pkg::REG_COMMIT, 16'h0000);
    t_commit = cycle;
    wait_sync_edge(1'b0, 1'b0, t_fall);
    period = 0;
    n      = 0;
    while (period != H_LE2 + 1 && n < V_FE + 3) begin
      wait_sync_edge(1'b0, 1'b0, t_next);
      period = t_next - t_fall;
      t_fall = t_next;
      n++;
    end
    check_true(period == H_LE2 + 1 && t_fall - t_commit <= FRAME2_CYCLES,
               "hsync period did not settle to the new line length within one frame");
    repeat (3) begin
      wait_sync_edge(1'b0, 1'b0, t_next);
      check_val("vga_hsync period", t_next - t_fall, H_LE2 + 1);
      t_fall = t_next;
    end
    wait_sync_edge(1'b1, 1'b1, t_next);
    scan_frame(1'b1, n_pix, n_err, n_late);
    check_val("vga_rgb pixels per frame", n_pix, H_VIS * V_VIS);
    check_val("vga_error pulses", n_err, 0);
    finish_test("reprogram", err_start);
  endtask

  task automatic test_underflow();
    int err_start;
    int n_pix;
    int n_err;
    int n_late;
    err_start = errors;
    reg_write(vga_pkg::REG_CTRL, 16'h0000);
    reg_write(vga_pkg::REG_COMMIT, 16'h0000);
    scan_frame(1'b0, n_pix, n_err, n_late);                // drains what is still buffered
    check_true(n_err > 0, "no underflow pulse after the pattern source was disabled");
    check_val("vga_rgb colored after underflow", n_late, 0);
    scan_frame(1'b0, n_pix, n_err, n_late);
    check_val("vga_error pulses per frame", n_err, H_VIS * V_VIS);
    check_val("vga_rgb nonzero samples", n_pix, 0);
    finish_test("underflow", err_start);
  endtask

  initial begin
    rst_n   <= 1'b0;
    wr_en   <= 1'b0;
    wr_addr <= '0;
    wr_data <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_hsync_timing();
    test_vsync_timing();
    test_pixel_content();
    test_reprogram();
    test_underflow();
    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verilog/vga_subsys_top.sv */
`timescale 1ns/1ps
`include "vga_macros.svh"

module vga_subsys_top (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           wr_en,
  input  logic [`VGA_REG_ADDR_WIDTH-1:0] wr_addr,
  input  logic [`VGA_REG_DATA_WIDTH-1:0] wr_data,

  output logic                           vga_hsync,
  output logic                           vga_vsync,
  output vga_pkg::pixel_t                vga_rgb,
  output logic                           vga_error
);
  vga_pkg::video_mode_t mode;
  vga_pkg::vga_ctrl_t   ctrl;
  logic                 pix_valid;
  vga_pkg::pixel_t      pix;
  logic                 pix_ready;

  video_mode_regs regs0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .mode   (mode),
    .ctrl   (ctrl)
  );

  pattern_gen gen0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .mode     (mode),
    .ctrl     (ctrl),
    .pix_valid(pix_valid),
    .pix      (pix),
    .pix_ready(pix_ready)
  );

  pix_vga vga0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_valid(pix_valid),
    .pix      (pix),
    .pix_ready(pix_ready),
    .mode     (mode),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_rgb  (vga_rgb),
    .vga_error(vga_error)
  );

endmodule

/* verilog/pix_vga.sv */
`timescale 1ns/1ps
`include "vga_macros.svh"

module pix_vga (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 pix_valid,
  input  vga_pkg::pixel_t      pix,
  output logic                 pix_ready,

  input  vga_pkg::video_mode_t mode,

  output logic                 vga_hsync,
  output logic                 vga_vsync,
  output vga_pkg::pixel_t      vga_rgb,
  output logic                 vga_error
);
  vga_pkg::pix_mode_t      in_bundle;
  vga_pkg::pix_mode_t      sb_data;
  logic                    sb_valid;
  logic                    sb_ready;

  logic                    enabled;
  logic                    en_next;
  logic                    visible;
  logic                    vis_next;

  logic [`VGA_H_WIDTH-1:0] x;
  logic [`VGA_H_WIDTH-1:0] x_next;
  logic [`VGA_H_WIDTH-1:0] x_adv;
  logic [`VGA_V_WIDTH-1:0] y;
  logic [`VGA_V_WIDTH-1:0] y_next;
  logic [`VGA_V_WIDTH-1:0] y_adv;

  assign in_bundle.pix  = pix;
  assign in_bundle.mode = mode;

  skid_buf #(
    .payload_t(vga_pkg::pix_mode_t)
  ) pix_sb (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (pix_valid),
    .in_data  (in_bundle),
    .in_ready (pix_ready),
    .out_valid(sb_valid),
    .out_data (sb_data),
    .out_ready(sb_ready)
  );

  assign en_next = enabled || sb_valid;

  // sticky, starts on the first buffered pixel
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enabled <= 1'b0;
    end else begin
      enabled <= en_next;
    end
  end

  always_comb begin
    x_next = x;
    y_next = y;
    if (x < sb_data.mode.h_line_end) begin
      x_next = x + 1'b1;
    end else begin
      x_next = '0;
      if (y < sb_data.mode.v_frame_end) begin
        y_next = y + 1'b1;
      end else begin
        y_next = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x <= '0;
      y <= '0;
    end else if (enabled) begin
      x <= x_next;
      y <= y_next;
    end
  end

  assign x_adv   = enabled ? x_next : x;           // position in the coming cycle
  assign y_adv   = enabled ? y_next : y;
  assign visible = enabled && (x < sb_data.mode.h_visible) && (y < sb_data.mode.v_visible);

  // ready registered one cycle ahead so the pixel taken is the one shown
  assign vis_next = en_next && (x_adv < sb_data.mode.h_visible)
                    && (y_adv < sb_data.mode.v_visible);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sb_ready  <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_rgb   <= '0;
      vga_error <= 1'b0;
    end else begin
      sb_ready  <= vis_next;
      vga_hsync <= !(enabled && x >= sb_data.mode.h_sync_start
                     && x < sb_data.mode.h_sync_end);
      vga_vsync <= !(enabled && y >= sb_data.mode.v_sync_start
                     && y < sb_data.mode.v_sync_end);
      vga_rgb   <= (visible && sb_valid) ? sb_data.pix : '0;
      vga_error <= visible && !sb_valid;           // underflow
    end
  end

endmodule

/* verilog/pattern_gen.sv */
`timescale 1ns/1ps
`include "vga_macros.svh"

module pattern_gen (
  input  logic                 clk,
  input  logic                 rst_n,

  input  vga_pkg::video_mode_t mode,
  input  vga_pkg::vga_ctrl_t   ctrl,

  output logic                 pix_valid,
  output vga_pkg::pixel_t      pix,
  input  logic                 pix_ready
);
  logic [`VGA_H_WIDTH-1:0] px;
  logic [`VGA_V_WIDTH-1:0] py;
  vga_pkg::pixel_t         gen_pix;
  logic                    gen_valid;
  logic                    gen_ready;
  logic                    gen_xfer;

  assign gen_valid = ctrl.gen_enable;
  assign gen_xfer  = gen_valid && gen_ready;

  always_comb begin
    gen_pix.red = px[`VGA_COLOR_WIDTH-1:0];
    gen_pix.grn = py[`VGA_COLOR_WIDTH-1:0];
    gen_pix.blu = '1;                              // keeps every visible pixel nonzero
  end

  // raster walk over the visible area only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      px <= '0;
      py <= '0;
    end else if (!ctrl.gen_enable) begin
      px <= '0;
      py <= '0;
    end else if (gen_xfer) begin
      if (px + 1'b1 < mode.h_visible) begin
        px <= px + 1'b1;
      end else begin
        px <= '0;
        if (py + 1'b1 < mode.v_visible) begin
          py <= py + 1'b1;
        end else begin
          py <= '0;
        end
      end
    end
  end

  skid_buf #(
    .payload_t(vga_pkg::pixel_t)
  ) pix_sb (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (gen_valid),
    .in_data  (gen_pix),
    .in_ready (gen_ready),
    .out_valid(pix_valid),
    .out_data (pix),
    .out_ready(pix_ready)
  );

endmodule

/* verilog/video_mode_regs.sv */
`timescale 1ns/1ps
`include "vga_macros.svh"

module video_mode_regs (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           wr_en,
  input  logic [`VGA_REG_ADDR_WIDTH-1:0] wr_addr,
  input  logic [`VGA_REG_DATA_WIDTH-1:0] wr_data,

  output vga_pkg::video_mode_t           mode,
  output vga_pkg::vga_ctrl_t             ctrl
);
  vga_pkg::video_mode_t    stage_mode;
  vga_pkg::vga_ctrl_t      stage_ctrl;
  logic [`VGA_H_WIDTH-1:0] wr_h;
  logic [`VGA_V_WIDTH-1:0] wr_v;
  logic                    commit;

  assign wr_h   = wr_data[`VGA_H_WIDTH-1:0];
  assign wr_v   = wr_data[`VGA_V_WIDTH-1:0];
  assign commit = wr_en && (wr_addr == vga_pkg::REG_COMMIT);

  // staging copy, written field by field
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_mode <= '0;
      stage_ctrl <= '0;
    end else if (wr_en) begin
      case (wr_addr)
        vga_pkg::REG_H_VISIBLE:    stage_mode.h_visible    <= wr_h;
        vga_pkg::REG_H_SYNC_START: stage_mode.h_sync_start <= wr_h;
        vga_pkg::REG_H_SYNC_END:   stage_mode.h_sync_end   <= wr_h;
        vga_pkg::REG_H_LINE_END:   stage_mode.h_line_end   <= wr_h;
        vga_pkg::REG_V_VISIBLE:    stage_mode.v_visible    <= wr_v;
        vga_pkg::REG_V_SYNC_START: stage_mode.v_sync_start <= wr_v;
        vga_pkg::REG_V_SYNC_END:   stage_mode.v_sync_end   <= wr_v;
        vga_pkg::REG_V_FRAME_END:  stage_mode.v_frame_end  <= wr_v;
        vga_pkg::REG_CTRL:         stage_ctrl.gen_enable   <= wr_data[0];
        default: ;                                       // commit and unused addresses
      endcase
    end
  end

  // active copy, all fields change together
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode <= '0;
      ctrl <= '0;
    end else if (commit) begin
      mode <= stage_mode;
      ctrl <= stage_ctrl;
    end
  end

endmodule

/* verilog/skid_buf.sv */
`timescale 1ns/1ps

module skid_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,

  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);
  logic     spare_valid;
  payload_t spare_data;
  logic     in_xfer;
  logic     out_free;

  assign in_ready = !spare_valid;                  // registered, no path from out_ready
  assign in_xfer  = in_valid && in_ready;
  assign out_free = !out_valid || out_ready;       // output entry can take a new item

  // control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid   <= 1'b0;
      spare_valid <= 1'b0;
    end else begin
      if (out_free) begin
        if (spare_valid) begin
          out_valid   <= 1'b1;
          spare_valid <= 1'b0;
        end else begin
          out_valid <= in_xfer;
        end
      end else if (in_xfer) begin
        spare_valid <= 1'b1;                         // consumer stalled, park it
      end
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (out_free) begin
      if (spare_valid) begin
        out_data <= spare_data;
      end else if (in_xfer) begin
        out_data <= in_data;
      end
    end else if (in_xfer) begin
      spare_data <= in_data;
    end
  end

endmodule

/* verilog/vga_pkg.sv */
`include "vga_macros.svh"

package vga_pkg;

  typedef struct packed {
    logic [`VGA_COLOR_WIDTH-1:0] red;
    logic [`VGA_COLOR_WIDTH-1:0] grn;
    logic [`VGA_COLOR_WIDTH-1:0] blu;
  } pixel_t;

  typedef struct packed {
    logic [`VGA_H_WIDTH-1:0] h_visible;
    logic [`VGA_H_WIDTH-1:0] h_sync_start;
    logic [`VGA_H_WIDTH-1:0] h_sync_end;
    logic [`VGA_H_WIDTH-1:0] h_line_end;    // last x of a line
    logic [`VGA_V_WIDTH-1:0] v_visible;
    logic [`VGA_V_WIDTH-1:0] v_sync_start;
    logic [`VGA_V_WIDTH-1:0] v_sync_end;
    logic [`VGA_V_WIDTH-1:0] v_frame_end;   // last y of a frame
  } video_mode_t;

  typedef struct packed {
    logic gen_enable;
  } vga_ctrl_t;

  // pixel travels with the mode it was generated for
  typedef struct packed {
    pixel_t      pix;
    video_mode_t mode;
  } pix_mode_t;

  localparam logic [`VGA_REG_ADDR_WIDTH-1:0] REG_H_VISIBLE    = 4'd0;
  localparam logic [`VGA_REG_ADDR_WIDTH-1:0] REG_H_SYNC_START = 4'd1;
  localparam logic [`VGA_REG_ADDR_WIDTH-1:0] REG_H_SYNC_END   = 4'd2;
  localparam logic [`VGA_REG_ADDR_WIDTH-1:0] REG_H_LINE_END   = 4'd3;
  localparam logic [`VGA_REG_ADDR_WIDTH-1:0] REG_V_VISIBLE    = 4'd4;
  localparam logic [`VGA_REG_ADDR_WIDTH-1:0] REG_V_SYNC_START = 4'd5;
  localparam logic [`VGA_REG_ADDR_WIDTH-1:0] REG_V_SYNC_END   = 4'd6;
  localparam logic [`VGA_REG_ADDR_WIDTH-1:0] REG_V_FRAME_END  = 4'd7;
  localparam logic [`VGA_REG_ADDR_WIDTH-1:0] REG_CTRL         = 4'd8;
  localparam logic [`VGA_REG_ADDR_WIDTH-1:0] REG_COMMIT       = 4'd9;

endpackage

/* verilog/vga_macros.svh */
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// coordinate widths
`define VGA_H_WIDTH 12
`define VGA_V_WIDTH 12

// per channel
`define VGA_COLOR_WIDTH 4

// host register port
`define VGA_REG_ADDR_WIDTH 4
`define VGA_REG_DATA_WIDTH 16

`endif
